/* source/dram_geom_pkg.sv */
package dram_geom_pkg;

    // two bank groups of two banks
    localparam int BANK_GROUPS     = 2;
    localparam int BANKS_PER_GROUP = 2;
    localparam int BANKS           = BANK_GROUPS * BANKS_PER_GROUP;
    localparam int BG_BITS         = $clog2(BANK_GROUPS);
    localparam int BA_BITS         = $clog2(BANKS_PER_GROUP);
    localparam int BANK_IDX_BITS   = BG_BITS + BA_BITS;   // flat index is {bg, ba}
    localparam int ROW_BITS        = 8;
    localparam int COL_BITS        = 4;
    localparam int PADDR_BITS      = ROW_BITS + BANK_IDX_BITS + COL_BITS;
    localparam int DATA_BITS       = 64;

    // row on top so consecutive addresses stay in one row
    typedef struct packed {
        logic [ROW_BITS-1:0] row;
        logic [BG_BITS-1:0]  bank_group;
        logic [BA_BITS-1:0]  bank;
        logic [COL_BITS-1:0] col;
    } bus_addr_t;

    typedef enum logic [1:0] {
        CMD_READ      = 2'd0,
        CMD_WRITE     = 2'd1,
        CMD_ACTIVATE  = 2'd2,
        CMD_PRECHARGE = 2'd3
    } cmd_e;

    localparam int CMD_WORD_BITS = 19;
    localparam int LOW_ADDR_BITS = 12;   // row or column, zero extended
    localparam int PIN_BITS      = 4;

    // activate form
    typedef struct packed {
        logic                     act_n;       // low for activate
        logic [PIN_BITS-1:0]      zeros;
        logic [BG_BITS-1:0]       bank_group;
        logic [BA_BITS-1:0]       bank;
        logic [LOW_ADDR_BITS-1:0] addr;        // row
    } row_word_t;

    // read, write and precharge form
    typedef struct packed {
        logic                     act_n;
        logic [PIN_BITS-1:0]      pins;        // command pins below act_n
        logic [BG_BITS-1:0]       bank_group;
        logic [BA_BITS-1:0]       bank;
        logic [LOW_ADDR_BITS-1:0] addr;        // column
    } col_word_t;

    typedef union packed {
        row_word_t row_form;
        col_word_t col_form;
    } cmd_word_u;

    localparam logic [PIN_BITS-1:0] PINS_WRITE     = 4'b1100;
    localparam logic [PIN_BITS-1:0] PINS_READ      = 4'b1101;
    localparam logic [PIN_BITS-1:0] PINS_PRECHARGE = 4'b1010;

    localparam cmd_word_u IDLE_WORD = {CMD_WORD_BITS{1'b1}};   // nothing on the bus

endpackage

/* source/sched_pkg.sv */
package sched_pkg;

    import dram_geom_pkg::*;

    localparam int AGE_BITS       = 32;
    localparam int QUEUE_DEPTH    = 8;
    localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_BITS = $clog2(QUEUE_DEPTH + 1);

    // bank busy times in cycles
    localparam int PRECHARGE_LATENCY  = 5;
    localparam int ACTIVATION_LATENCY = 8;
    localparam int ACCESS_LATENCY     = 1;
    localparam int BUSY_BITS          = $clog2(ACTIVATION_LATENCY);   // holds latency - 1

    // same-kind command spacing
    localparam int READ_GAP  = 4;
    localparam int WRITE_GAP = 4;

    typedef struct packed {
        logic [BG_BITS-1:0]   bank_group;
        logic [BA_BITS-1:0]   bank;
        logic [ROW_BITS-1:0]  row;
        logic [COL_BITS-1:0]  col;
        logic [DATA_BITS-1:0] data;
        logic                 write;
        logic [AGE_BITS-1:0]  age;     // cycle of arrival
    } req_entry_t;

    typedef struct packed {
        logic       valid;   // queue not empty
        req_entry_t entry;
    } queue_head_t;

    typedef struct packed {
        logic                is_open;
        logic [ROW_BITS-1:0] row;
        logic                busy;
    } bank_view_t;

endpackage

/* source/request_queue.sv */
`timescale 1ns/1ps

module request_queue (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  logic                   push,
    input  sched_pkg::req_entry_t  entry,
    input  logic                   pop,
    output sched_pkg::queue_head_t head,
    output logic                   full
);

    import sched_pkg::*;

    req_entry_t                mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_BITS-1:0] wr_ptr;
    logic [QUEUE_PTR_BITS-1:0] rd_ptr;
    logic [QUEUE_CNT_BITS-1:0] count;
    logic [AGE_BITS-1:0]       age_cnt;   // free running cycle count
    req_entry_t                stamped;

    function automatic logic [QUEUE_PTR_BITS-1:0] next_ptr(
        input logic [QUEUE_PTR_BITS-1:0] ptr
    );
        return (ptr == QUEUE_PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        stamped     = entry;
        stamped.age = age_cnt;   // arrival time decides read/write priority
    end

    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= stamped;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            age_cnt <= '0;
        end else begin
            age_cnt <= age_cnt + 1'b1;
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    assign head.valid = (count != '0);
    assign head.entry = mem[rd_ptr];
    assign full       = (count == QUEUE_CNT_BITS'(QUEUE_DEPTH));

    // the top has no handshake, so the sender must respect full
    a_no_push_full: assert property (@(posedge clk_in) disable iff (rst_in)
        push |-> !full)
        else $error("request_queue: push while full");

    a_no_pop_empty: assert property (@(posedge clk_in) disable iff (rst_in)
        pop |-> head.valid)
        else $error("request_queue: pop while empty");

endmodule

/* source/bank_state.sv */
`timescale 1ns/1ps

module bank_state (
    input  logic                                     clk_in,
    input  logic                                     rst_in,
    input  logic                                     issue,
    input  dram_geom_pkg::cmd_e                      cmd,
    input  logic [dram_geom_pkg::BANK_IDX_BITS-1:0]  bank_idx,
    input  logic [dram_geom_pkg::ROW_BITS-1:0]       row,
    output sched_pkg::bank_view_t [dram_geom_pkg::BANKS-1:0] banks
);

    import dram_geom_pkg::*;
    import sched_pkg::*;

    logic [BUSY_BITS-1:0] load_val;
    bank_view_t           target;   // bank addressed by the current command

    // the issue cycle itself counts, so load one less than the latency
    always_comb begin
        case (cmd)
            CMD_PRECHARGE: load_val = BUSY_BITS'(PRECHARGE_LATENCY - 1);
            CMD_ACTIVATE:  load_val = BUSY_BITS'(ACTIVATION_LATENCY - 1);
            default:       load_val = BUSY_BITS'(ACCESS_LATENCY - 1);
        endcase
    end

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        logic                 hit;
        logic                 open_q;
        logic [ROW_BITS-1:0]  row_q;
        logic [BUSY_BITS-1:0] busy_cnt;

        assign hit = issue && (bank_idx == BANK_IDX_BITS'(b));

        always_ff @(posedge clk_in or posedge rst_in) begin
            if (rst_in) begin
                open_q   <= 1'b0;
                busy_cnt <= '0;
            end else if (hit) begin
                busy_cnt <= load_val;
                if (cmd == CMD_ACTIVATE) begin
                    open_q <= 1'b1;
                end else if (cmd == CMD_PRECHARGE) begin
                    open_q <= 1'b0;
                end
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end
        end

        always_ff @(posedge clk_in) begin
            if (hit && cmd == CMD_ACTIVATE) begin
                row_q <= row;   // row latched on activate
            end
        end

        assign banks[b].is_open = open_q;
        assign banks[b].row     = row_q;
        assign banks[b].busy    = (busy_cnt != '0);
    end

    assign target = banks[bank_idx];

    // activate wants a closed bank, everything else an open one
    a_open_state: assert property (@(posedge clk_in) disable iff (rst_in)
        issue |-> ((cmd == CMD_ACTIVATE) != target.is_open))
        else $error("bank_state: command %0d to bank %0d in wrong open state", cmd, bank_idx);

    a_row_hit: assert property (@(posedge clk_in) disable iff (rst_in)
        issue && (cmd == CMD_READ || cmd == CMD_WRITE) |-> target.row == row)
        else $error("bank_state: access to bank %0d misses open row", bank_idx);

    a_not_busy: assert property (@(posedge clk_in) disable iff (rst_in)
        issue |-> !target.busy)
        else $error("bank_state: command to busy bank %0d", bank_idx);

endmodule

/* source/cmd_arbiter.sv */
`timescale 1ns/1ps

module cmd_arbiter (
    input  logic                                 clk_in,
    input  logic                                 rst_in,
    input  logic                                 cmd_ready,
    input  logic                                 bursting,
    input  sched_pkg::queue_head_t               read_head,
    input  sched_pkg::queue_head_t               write_head,
    output logic                                 read_pop,
    output logic                                 write_pop,
    output logic                                 valid_out,
    output dram_geom_pkg::cmd_e                  cmd_out,
    output logic [dram_geom_pkg::BG_BITS-1:0]    bank_group_out,
    output logic [dram_geom_pkg::BA_BITS-1:0]    bank_out,
    output logic [dram_geom_pkg::ROW_BITS-1:0]   row_out,
    output logic [dram_geom_pkg::COL_BITS-1:0]   col_out,
    output logic [dram_geom_pkg::DATA_BITS-1:0]  val_out,
    output dram_geom_pkg::cmd_word_u             addr_out
);

    import dram_geom_pkg::*;
    import sched_pkg::*;

    queue_head_t              heads     [2];   // 0 read, 1 write
    logic [BANK_IDX_BITS-1:0] head_bank [2];
    cmd_e                     head_cmd  [2];
    logic [1:0]               servable;
    bank_view_t [BANKS-1:0]   banks;

    logic [AGE_BITS-1:0]      cycle_cnt;
    logic [AGE_BITS-1:0]      last_read;
    logic [AGE_BITS-1:0]      last_write;
    logic                     read_gap_ok;
    logic                     write_gap_ok;

    logic                     write_first;   // write head is older
    logic                     take;
    logic                     sel;           // 1 picks the write head
    req_entry_t               pick;
    cmd_e                     pick_cmd;
    logic [BANK_IDX_BITS-1:0] pick_bank;
    logic                     access;
    cmd_word_u                word;

    assign heads[0] = read_head;
    assign heads[1] = write_head;

    assign read_gap_ok  = (cycle_cnt - last_read) >= AGE_BITS'(READ_GAP);
    assign write_gap_ok = (cycle_cnt - last_write) >= AGE_BITS'(WRITE_GAP);

    // next command of each head follows from its bank
    always_comb begin
        for (int h = 0; h < 2; h++) begin
            head_bank[h] = {heads[h].entry.bank_group, heads[h].entry.bank};
            if (!banks[head_bank[h]].is_open) begin
                head_cmd[h] = CMD_ACTIVATE;
            end else if (banks[head_bank[h]].row != heads[h].entry.row) begin
                head_cmd[h] = CMD_PRECHARGE;   // wrong row open
            end else if (heads[h].entry.write) begin
                head_cmd[h] = CMD_WRITE;
            end else begin
                head_cmd[h] = CMD_READ;
            end
            servable[h] = heads[h].valid && !banks[head_bank[h]].busy
                && (head_cmd[h] != CMD_READ || read_gap_ok)
                && (head_cmd[h] != CMD_WRITE || write_gap_ok)
                && (h == 0 || !bursting);   // writes wait out a burst
        end
    end

    // an empty head never counts as older, read wins a tie
    assign write_first = write_head.valid
        && (!read_head.valid || write_head.entry.age < read_head.entry.age);

    always_comb begin
        sel  = write_first;
        take = 1'b0;
        if (cmd_ready) begin
            if (servable[write_first]) begin
                take = 1'b1;
            end else if (servable[!write_first] && head_bank[0] != head_bank[1]) begin
                sel  = !write_first;   // younger head may pass only on another bank
                take = 1'b1;
            end
        end
    end

    assign pick      = heads[sel].entry;
    assign pick_cmd  = head_cmd[sel];
    assign pick_bank = head_bank[sel];
    assign access    = (pick_cmd == CMD_READ) || (pick_cmd == CMD_WRITE);

    // activate and precharge leave the request queued
    assign read_pop  = take && !sel && access;
    assign write_pop = take && sel && access;

    always_comb begin
        word = IDLE_WORD;
        if (pick_cmd == CMD_ACTIVATE) begin
            word.row_form.act_n      = 1'b0;
            word.row_form.zeros      = '0;
            word.row_form.bank_group = pick.bank_group;
            word.row_form.bank       = pick.bank;
            word.row_form.addr       = LOW_ADDR_BITS'(pick.row);
        end else begin
            word.col_form.act_n      = 1'b1;
            case (pick_cmd)
                CMD_WRITE: word.col_form.pins = PINS_WRITE;
                CMD_READ:  word.col_form.pins = PINS_READ;
                default:   word.col_form.pins = PINS_PRECHARGE;
            endcase
            word.col_form.bank_group = pick.bank_group;
            word.col_form.bank       = pick.bank;
            word.col_form.addr       = LOW_ADDR_BITS'(pick.col);
        end
    end

    bank_state bank_table (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .issue    (take),
        .cmd      (pick_cmd),
        .bank_idx (pick_bank),
        .row      (pick.row),
        .banks    (banks)
    );

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            cycle_cnt  <= '0;
            last_read  <= AGE_BITS'(0) - AGE_BITS'(READ_GAP);    // first read may go at once
            last_write <= AGE_BITS'(0) - AGE_BITS'(WRITE_GAP);
            valid_out  <= 1'b0;
            addr_out   <= IDLE_WORD;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            valid_out <= take;
            addr_out  <= take ? word : IDLE_WORD;
            if (take && pick_cmd == CMD_READ) begin
                last_read <= cycle_cnt;
            end
            if (take && pick_cmd == CMD_WRITE) begin
                last_write <= cycle_cnt;
            end
        end
    end

    // decoded fields, qualified by valid_out
    always_ff @(posedge clk_in) begin
        if (take) begin
            cmd_out        <= pick_cmd;
            bank_group_out <= pick.bank_group;
            bank_out       <= pick.bank;
            row_out        <= pick.row;
            col_out        <= pick.col;
            val_out        <= (pick_cmd == CMD_WRITE) ? pick.data : '0;
        end
    end

    a_valid_not_idle: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_out |-> addr_out != IDLE_WORD)
        else $error("cmd_arbiter: valid command carries the idle word");

endmodule

/* source/request_scheduler.sv */
`timescale 1ns/1ps

module request_scheduler (
    input  logic                                 clk_in,
    input  logic                                 rst_in,
    input  logic                                 valid_in,
    input  logic                                 write_in,
    input  logic [dram_geom_pkg::PADDR_BITS-1:0] mem_bus_addr_in,
    input  logic [dram_geom_pkg::DATA_BITS-1:0]  val_in,
    input  logic                                 cmd_ready,
    input  logic                                 bursting,
    output logic                                 read_full,
    output logic                                 write_full,
    output logic                                 valid_out,
    output dram_geom_pkg::cmd_e                  cmd_out,
    output logic [dram_geom_pkg::BG_BITS-1:0]    bank_group_out,
    output logic [dram_geom_pkg::BA_BITS-1:0]    bank_out,
    output logic [dram_geom_pkg::ROW_BITS-1:0]   row_out,
    output logic [dram_geom_pkg::COL_BITS-1:0]   col_out,
    output logic [dram_geom_pkg::DATA_BITS-1:0]  val_out,
    output dram_geom_pkg::cmd_word_u             addr_out
);

    import dram_geom_pkg::*;
    import sched_pkg::*;

    bus_addr_t   addr_view;
    req_entry_t  new_entry;
    queue_head_t read_head;
    queue_head_t write_head;
    logic        read_pop;
    logic        write_pop;

    assign addr_view = mem_bus_addr_in;

    assign new_entry = '{
        bank_group: addr_view.bank_group,
        bank:       addr_view.bank,
        row:        addr_view.row,
        col:        addr_view.col,
        data:       val_in,
        write:      write_in,
        age:        '0           // stamped inside the queue
    };

    request_queue read_queue (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .push   (valid_in && !write_in),
        .entry  (new_entry),
        .pop    (read_pop),
        .head   (read_head),
        .full   (read_full)
    );

    request_queue write_queue (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .push   (valid_in && write_in),
        .entry  (new_entry),
        .pop    (write_pop),
        .head   (write_head),
        .full   (write_full)
    );

    cmd_arbiter arbiter (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .cmd_ready      (cmd_ready),
        .bursting       (bursting),
        .read_head      (read_head),
        .write_head     (write_head),
        .read_pop       (read_pop),
        .write_pop      (write_pop),
        .valid_out      (valid_out),
        .cmd_out        (cmd_out),
        .bank_group_out (bank_group_out),
        .bank_out       (bank_out),
        .row_out        (row_out),
        .col_out        (col_out),
        .val_out        (val_out),
        .addr_out       (addr_out)
    );

endmodule

/* verif/tb_request_scheduler.sv */
`timescale 1ns/1ps

module tb_request_scheduler;

    import dram_geom_pkg::*;
    import sched_pkg::*;

    localparam int          CLK_PERIOD      = 20;
    localparam int          NUM_REQ         = 200;
    localparam int          WATCHDOG_CYCLES = NUM_REQ * 60;
    localparam logic [18:0] IDLE            = 19'h7ffff;   // no command on the bus

    typedef struct packed {
        logic [BG_BITS-1:0]   bank_group;
        logic [BA_BITS-1:0]   bank;
        logic [ROW_BITS-1:0]  row;
        logic [COL_BITS-1:0]  col;
        logic [DATA_BITS-1:0] data;
    } model_req_t;

    logic                  clk_in = 1'b0;
    logic                  rst_in;
    logic                  valid_in;
    logic                  write_in;
    logic [PADDR_BITS-1:0] mem_bus_addr_in;
    logic [DATA_BITS-1:0]  val_in;
    logic                  cmd_ready;
    logic                  bursting;
    logic                  read_full;
    logic                  write_full;
    logic                  valid_out;
    cmd_e                  cmd_out;
    logic [BG_BITS-1:0]    bank_group_out;
    logic [BA_BITS-1:0]    bank_out;
    logic [ROW_BITS-1:0]   row_out;
    logic [COL_BITS-1:0]   col_out;
    logic [DATA_BITS-1:0]  val_out;
    cmd_word_u             addr_out;

    // model state, touched only by the monitor and the request driver
    model_req_t           rd_q[$];
    model_req_t           wr_q[$];
    logic                 bank_open  [BANKS];
    logic [ROW_BITS-1:0]  bank_row   [BANKS];
    int                   busy_until [BANKS];   // first cycle the bank may take a command
    int                   cyc;
    int                   last_read_cyc;
    int                   last_write_cyc;
    logic                 prev_ready;
    logic                 prev_bursting;
    logic                 drained;
    int                   seed;

    request_scheduler dut0 (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .valid_in        (valid_in),
        .write_in        (write_in),
        .mem_bus_addr_in (mem_bus_addr_in),
        .val_in          (val_in),
        .cmd_ready       (cmd_ready),
        .bursting        (bursting),
        .read_full       (read_full),
        .write_full      (write_full),
        .valid_out       (valid_out),
        .cmd_out         (cmd_out),
        .bank_group_out  (bank_group_out),
        .bank_out        (bank_out),
        .row_out         (row_out),
        .col_out         (col_out),
        .val_out         (val_out),
        .addr_out        (addr_out)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic mismatch_stop(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h (cycle %0d)",
                            name, got, exp, cyc));
    endtask

    // command word as the DRAM bus defines it
    function automatic logic [18:0] expected_word(input cmd_e c, input logic bg,
                                                  input logic ba, input logic [7:0] row,
                                                  input logic [3:0] col);
        logic [3:0] pins;
        case (c)
            CMD_WRITE: pins = 4'b1100;
            CMD_READ:  pins = 4'b1101;
            default:   pins = 4'b1010;   // precharge
        endcase
        if (c == CMD_ACTIVATE) begin
            return {1'b0, 4'b0000, bg, ba, 4'h0, row};
        end
        return {1'b1, pins, bg, ba, 8'h00, col};
    endfunction

    function automatic int bank_latency(input cmd_e c);
        case (c)
            CMD_ACTIVATE:  return ACTIVATION_LATENCY;
            CMD_PRECHARGE: return PRECHARGE_LATENCY;
            default:       return ACCESS_LATENCY;
        endcase
    endfunction

    task automatic match_request(input model_req_t req);
        assert (bank_group_out == req.bank_group)
            else mismatch_stop("bank_group_out", 64'(bank_group_out), 64'(req.bank_group));
        assert (bank_out == req.bank) else mismatch_stop("bank_out", 64'(bank_out), 64'(req.bank));
        assert (row_out == req.row) else mismatch_stop("row_out", 64'(row_out), 64'(req.row));
        assert (col_out == req.col) else mismatch_stop("col_out", 64'(col_out), 64'(req.col));
    endtask

    // a push driven this cycle is already in the model but reaches the queue at the next edge
    task automatic check_full();
        int   rd_held;
        int   wr_held;
        logic exp_rd;
        logic exp_wr;
        rd_held = rd_q.size() - ((valid_in && !write_in) ? 1 : 0);
        wr_held = wr_q.size() - ((valid_in && write_in) ? 1 : 0);
        exp_rd  = (rd_held == QUEUE_DEPTH);
        exp_wr  = (wr_held == QUEUE_DEPTH);
        assert (read_full == exp_rd)
            else mismatch_stop("read_full", 64'(read_full), 64'(exp_rd));
        assert (write_full == exp_wr)
            else mismatch_stop("write_full", 64'(write_full), 64'(exp_wr));
    endtask

    task automatic check_output();
        logic [1:0]  b;
        logic [18:0] got_word;
        logic [18:0] exp_word;
        model_req_t  req;
        b        = {bank_group_out, bank_out};
        got_word = addr_out;
        if (!prev_ready) begin
            assert (!valid_out) else mismatch_stop("valid_out", 64'(valid_out), 64'(0));
        end
        if (!valid_out) begin
            assert (got_word == IDLE) else mismatch_stop("addr_out", 64'(got_word), 64'(IDLE));
            return;
        end
        assert (!drained) else abort_run("command issued after all requests were served");
        exp_word = expected_word(cmd_out, bank_group_out, bank_out, row_out, col_out);
        assert (got_word == exp_word) else mismatch_stop("addr_out", 64'(got_word), 64'(exp_word));

        assert (cyc >= busy_until[b])
            else abort_run($sformatf("command to bank %0d at cycle %0d, bank busy until %0d",
                                     b, cyc, busy_until[b]));
        case (cmd_out)
            CMD_ACTIVATE: begin
                assert (!bank_open[b]) else abort_run($sformatf("activate to open bank %0d", b));
                bank_open[b] = 1'b1;
                bank_row[b]  = row_out;
            end
            CMD_PRECHARGE: begin
                assert (bank_open[b]) else abort_run($sformatf("precharge to closed bank %0d", b));
                bank_open[b] = 1'b0;
            end
            default: begin
                assert (bank_open[b]) else abort_run($sformatf("access to closed bank %0d", b));
                assert (row_out == bank_row[b])
                    else mismatch_stop("row_out", 64'(row_out), 64'(bank_row[b]));
            end
        endcase
        busy_until[b] = cyc + bank_latency(cmd_out);

        if (cmd_out == CMD_READ) begin
            assert (cyc - last_read_cyc >= READ_GAP)
                else abort_run($sformatf("reads only %0d cycles apart", cyc - last_read_cyc));
            last_read_cyc = cyc;
            assert (rd_q.size() != 0) else abort_run("read issued with no outstanding read");
            req = rd_q.pop_front();   // read queue is FIFO, oldest read goes first
            match_request(req);
        end
        if (cmd_out == CMD_WRITE) begin
            assert (cyc - last_write_cyc >= WRITE_GAP)
                else abort_run($sformatf("writes only %0d cycles apart", cyc - last_write_cyc));
            assert (!prev_bursting) else abort_run("write issued during a burst");
            last_write_cyc = cyc;
            assert (wr_q.size() != 0) else abort_run("write issued with no outstanding write");
            req = wr_q.pop_front();
            match_request(req);
            assert (val_out == req.data) else mismatch_stop("val_out", val_out, req.data);
        end
    endtask

    // outputs move on the rising edge, so look at them mid cycle
    always @(negedge clk_in) begin
        if (rst_in) begin
            assert (!valid_out) else mismatch_stop("valid_out", 64'(valid_out), 64'(0));
            assert (addr_out == IDLE) else mismatch_stop("addr_out", 64'(addr_out), 64'(IDLE));
            assert (!read_full) else mismatch_stop("read_full", 64'(read_full), 64'(0));
            assert (!write_full) else mismatch_stop("write_full", 64'(write_full), 64'(0));
        end else begin
            check_output();
            check_full();
            cyc = cyc + 1;
        end
        prev_ready    = cmd_ready;
        prev_bursting = bursting;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        abort_run($sformatf("timeout: %0d reads and %0d writes still outstanding",
                            rd_q.size(), wr_q.size()));
    end

    initial begin
        logic [31:0] r;
        model_req_t  req;
        int          sent;
        seed            = 77577;
        rst_in          = 1'b1;
        valid_in        = 1'b0;
        write_in        = 1'b0;
        mem_bus_addr_in = '0;
        val_in          = '0;
        cmd_ready       = 1'b0;
        bursting        = 1'b0;
        for (int i = 0; i < BANKS; i++) begin
            bank_open[i]  = 1'b0;
            bank_row[i]   = '0;
            busy_until[i] = 0;
        end
        cyc            = 0;
        last_read_cyc  = -READ_GAP;
        last_write_cyc = -WRITE_GAP;
        prev_ready     = 1'b0;
        prev_bursting  = 1'b0;
        drained        = 1'b0;
        sent           = 0;

        repeat (5) @(posedge clk_in);
        #2;
        rst_in = 1'b0;

        while (sent < NUM_REQ) begin
            @(posedge clk_in);
            #2;
            r         = $random(seed);
            cmd_ready = (r[1:0] != 2'b00);   // slot busy about a quarter of the time
            bursting  = (r[4:2] == 3'b000);
            valid_in  = 1'b0;
            write_in  = r[6];
            if (r[5] && !(r[6] ? write_full : read_full)) begin
                r              = $random(seed);
                req.bank_group = r[8];
                req.bank       = r[9];
                req.row        = {6'b000000, r[1:0]};   // few rows, so hits happen
                req.col        = r[7:4];
                req.data       = {$random(seed), $random(seed)};
                mem_bus_addr_in = {req.row, req.bank_group, req.bank, req.col};
                val_in          = req.data;
                valid_in        = 1'b1;
                if (write_in) begin
                    wr_q.push_back(req);
                end else begin
                    rd_q.push_back(req);
                end
                sent = sent + 1;
            end
        end

        // drain with the slot always free
        @(posedge clk_in);
        #2;
        valid_in  = 1'b0;
        cmd_ready = 1'b1;
        bursting  = 1'b0;
        while (rd_q.size() != 0 || wr_q.size() != 0) @(posedge clk_in);
        drained = 1'b1;
        repeat (20) @(posedge clk_in);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* src.f */
source/dram_geom_pkg.sv
source/sched_pkg.sv
source/request_queue.sv
source/bank_state.sv
source/cmd_arbiter.sv
source/request_scheduler.sv
verif/tb_request_scheduler.sv

/* Makefile */
# Verilator simulation of the request scheduler testbench

VERILATOR ?= verilator
TOP       ?= tb_request_scheduler
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
